// File: hw/rv_pkg.sv
/* Shared RV32I definitions for the single-cycle core. Only the opcodes and
   branch codes the core executes are listed here. */
package rv_pkg;

  localparam int XLEN       = 32;           // Data and address width
  localparam int REG_ADDR_W = 5;            // Register index width

  typedef enum logic [6:0] {
    OP_R       = 7'b0110011,                // add sub and or xor
    OP_I_ARITH = 7'b0010011,                // addi andi ori xori
    OP_LOAD    = 7'b0000011,                // lw
    OP_STORE   = 7'b0100011,                // sw
    OP_BRANCH  = 7'b1100011,                // beq blt bgeu
    OP_LUI     = 7'b0110111,
    OP_JAL     = 7'b1101111,
    OP_JALR    = 7'b1100111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_t;

  // One instruction word, viewed per encoding format
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      opcode_t               opcode;
    } r;
    struct packed {
      logic [11:0]           imm;           // inst[31:20]
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      opcode_t               opcode;
    } i;
    struct packed {
      logic [6:0]            imm_hi;        // inst[31:25], also B imm bits
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;        // inst[11:7]
      opcode_t               opcode;
    } s;
    struct packed {
      logic [19:0]           imm;           // inst[31:12], also J imm bits
      logic [REG_ADDR_W-1:0] rd;
      opcode_t               opcode;
    } u;
  } inst_t;

  // Branch conditions kept by the core
  localparam logic [2:0] BR_FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] BR_FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] BR_FUNCT3_BGEU = 3'b111;

endpackage

// File: hw/rv_main_decoder.sv
/* Opcode to datapath control levels. Unknown opcodes give all zeros, so
   they neither write a register nor store. */
module rv_main_decoder (
  input  rv_pkg::opcode_t opcode,
  output logic            reg_write,
  output logic            alu_src,
  output logic            mem_to_reg,
  output logic            mem_write,
  output logic            branch,
  output logic            jal,
  output logic            jalr,
  output logic            lui
);

  always_comb begin
    reg_write  = 1'b0;
    alu_src    = 1'b0;
    mem_to_reg = 1'b0;
    mem_write  = 1'b0;
    branch     = 1'b0;
    jal        = 1'b0;
    jalr       = 1'b0;
    lui        = 1'b0;
    case (opcode)
      rv_pkg::OP_R: begin
        reg_write = 1'b1;                   // rs1 op rs2
      end
      rv_pkg::OP_I_ARITH: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;                   // Immediate operand
      end
      rv_pkg::OP_LOAD: begin
        reg_write  = 1'b1;
        alu_src    = 1'b1;                  // Address is rs1 + imm_i
        mem_to_reg = 1'b1;
      end
      rv_pkg::OP_STORE: begin
        alu_src   = 1'b1;                   // Top picks imm_s with mem_write
        mem_write = 1'b1;
      end
      rv_pkg::OP_BRANCH: begin
        branch = 1'b1;                      // Compare through ALU subtract
      end
      rv_pkg::OP_LUI: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        lui       = 1'b1;                   // 0 + imm_u
      end
      rv_pkg::OP_JAL: begin
        reg_write = 1'b1;                   // Link written as pc+4
        alu_src   = 1'b1;
        jal       = 1'b1;
      end
      rv_pkg::OP_JALR: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;                   // Target is rs1 + imm_i
        jalr      = 1'b1;
      end
      default: ;                            // Nothing written or stored
    endcase
  end

endmodule

// File: hw/rv_alu_decoder.sv
/* ALU operation from opcode and funct fields. Funct codes outside the kept
   set decode as add. */
module rv_alu_decoder (
  input  rv_pkg::inst_t   inst,
  output rv_pkg::alu_op_t alu_op
);

  always_comb begin
    alu_op = rv_pkg::ALU_ADD;               // Loads, stores, lui, jumps
    case (inst.r.opcode)
      rv_pkg::OP_R: begin
        case ({inst.r.funct7, inst.r.funct3})
          10'b0000000_000: alu_op = rv_pkg::ALU_ADD;
          10'b0100000_000: alu_op = rv_pkg::ALU_SUB;
          10'b0000000_111: alu_op = rv_pkg::ALU_AND;
          10'b0000000_110: alu_op = rv_pkg::ALU_OR;
          10'b0000000_100: alu_op = rv_pkg::ALU_XOR;
          default:         alu_op = rv_pkg::ALU_ADD;
        endcase
      end
      rv_pkg::OP_I_ARITH: begin
        // No funct7 here, imm fills those bits
        case (inst.i.funct3)
          3'b000:  alu_op = rv_pkg::ALU_ADD;
          3'b111:  alu_op = rv_pkg::ALU_AND;
          3'b110:  alu_op = rv_pkg::ALU_OR;
          3'b100:  alu_op = rv_pkg::ALU_XOR;
          default: alu_op = rv_pkg::ALU_ADD;
        endcase
      end
      rv_pkg::OP_BRANCH: begin
        alu_op = rv_pkg::ALU_SUB;           // Flags of rs1 - rs2 decide
      end
      default: ;
    endcase
  end

endmodule

// File: hw/rv_imm_gen.sv
/* Sign-extended immediates for every kept format, all built in parallel.
   B and J offsets are halfword aligned, bit 0 is always zero. */
module rv_imm_gen (
  input  rv_pkg::inst_t                inst,
  output logic [rv_pkg::XLEN-1:0]      imm_i,
  output logic [rv_pkg::XLEN-1:0]      imm_s,
  output logic [rv_pkg::XLEN-1:0]      imm_b,
  output logic [rv_pkg::XLEN-1:0]      imm_u,
  output logic [rv_pkg::XLEN-1:0]      imm_j
);

  logic sign;                               // inst[31] in every format

  assign sign = inst.i.imm[11];

  assign imm_i = {{(rv_pkg::XLEN-12){sign}}, inst.i.imm};

  assign imm_s = {{(rv_pkg::XLEN-12){sign}}, inst.s.imm_hi, inst.s.imm_lo};

  // B reuses the S fields, inst[7] moves up to bit 11
  assign imm_b = {{(rv_pkg::XLEN-13){sign}},
                  inst.s.imm_hi[6],         // imm[12]
                  inst.s.imm_lo[0],         // imm[11]
                  inst.s.imm_hi[5:0],       // imm[10:5]
                  inst.s.imm_lo[4:1],       // imm[4:1]
                  1'b0};

  assign imm_u = {inst.u.imm, 12'b0};

  // J scrambles the U field
  assign imm_j = {{(rv_pkg::XLEN-21){sign}},
                  inst.u.imm[19],           // imm[20]
                  inst.u.imm[7:0],          // imm[19:12]
                  inst.u.imm[8],            // imm[11]
                  inst.u.imm[18:9],         // imm[10:1]
                  1'b0};

endmodule

// File: hw/rv_regfile.sv
/* NUM_REGS of 16 gives an RV32E-sized file; higher indexes read zero and
   ignore writes. x0 always reads zero. */
module rv_regfile #(
  parameter int NUM_REGS = 32
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          we,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr,
  input  logic [rv_pkg::XLEN-1:0]       rd_data,
  output logic [rv_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_pkg::XLEN-1:0]       rs2_data
);

  logic [rv_pkg::XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int k = 0; k < NUM_REGS; k++) regs[k] <= '0;
    end else if (we && rd_addr != '0 && rd_addr < NUM_REGS) begin
      regs[rd_addr] <= rd_data;             // x0 writes dropped
    end
  end

  // Combinational reads, same-cycle write not bypassed
  assign rs1_data = (rs1_addr != '0 && rs1_addr < NUM_REGS) ? regs[rs1_addr] : '0;
  assign rs2_data = (rs2_addr != '0 && rs2_addr < NUM_REGS) ? regs[rs2_addr] : '0;

endmodule

// File: hw/rv_alu.sv
/* Single ALU with N Z C V flags taken from the adder path. On subtract C is
   set when a >= b unsigned, as in a + ~b + 1. */
module rv_alu (
  input  logic [rv_pkg::XLEN-1:0] a,
  input  logic [rv_pkg::XLEN-1:0] b,
  input  rv_pkg::alu_op_t         alu_op,
  output logic [rv_pkg::XLEN-1:0] result,
  output logic                    flag_n,
  output logic                    flag_z,
  output logic                    flag_c,
  output logic                    flag_v
);

  logic                    is_sub;
  logic [rv_pkg::XLEN-1:0] b_eff;           // b or its inverse
  logic [rv_pkg::XLEN:0]   sum;             // Extra bit holds carry out

  assign is_sub = (alu_op == rv_pkg::ALU_SUB);
  assign b_eff  = is_sub ? ~b : b;
  assign sum    = {1'b0, a} + {1'b0, b_eff} + {{rv_pkg::XLEN{1'b0}}, is_sub};

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD: result = sum[rv_pkg::XLEN-1:0];
      rv_pkg::ALU_SUB: result = sum[rv_pkg::XLEN-1:0];
      rv_pkg::ALU_AND: result = a & b;
      rv_pkg::ALU_OR:  result = a | b;
      rv_pkg::ALU_XOR: result = a ^ b;
      default:         result = sum[rv_pkg::XLEN-1:0];
    endcase
  end

  assign flag_n = sum[rv_pkg::XLEN-1];
  assign flag_z = (sum[rv_pkg::XLEN-1:0] == '0);
  assign flag_c = sum[rv_pkg::XLEN];
  // Overflow when operand signs agree and the sum sign differs
  assign flag_v = (a[rv_pkg::XLEN-1] == b_eff[rv_pkg::XLEN-1]) &&
                  (sum[rv_pkg::XLEN-1] != a[rv_pkg::XLEN-1]);

endmodule

// File: hw/rv_pc_unit.sv
/* Program counter and next-address select. Branch decision uses the flags
   of rs1 - rs2; only beq, blt and bgeu can be taken. */
module rv_pc_unit #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    branch,
  input  logic                    jal,
  input  logic                    jalr,
  input  logic [2:0]              funct3,
  input  logic                    flag_n,
  input  logic                    flag_z,
  input  logic                    flag_c,
  input  logic                    flag_v,
  input  logic [rv_pkg::XLEN-1:0] imm_b,
  input  logic [rv_pkg::XLEN-1:0] imm_j,
  input  logic [rv_pkg::XLEN-1:0] alu_result,
  output logic [rv_pkg::XLEN-1:0] pc,
  output logic [rv_pkg::XLEN-1:0] pc_plus4
);

  logic                    cond;            // Condition met for this funct3
  logic [rv_pkg::XLEN-1:0] next_pc;

  always_comb begin
    case (funct3)
      rv_pkg::BR_FUNCT3_BEQ:  cond = flag_z;
      rv_pkg::BR_FUNCT3_BLT:  cond = (flag_n != flag_v); // Signed less than
      rv_pkg::BR_FUNCT3_BGEU: cond = flag_c;            // No borrow
      default:                cond = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + rv_pkg::XLEN'(4);

  always_comb begin
    if (branch && cond) begin
      next_pc = pc + imm_b;
    end else if (jal) begin
      next_pc = pc + imm_j;
    end else if (jalr) begin
      next_pc = {alu_result[rv_pkg::XLEN-1:1], 1'b0}; // Bit 0 cleared
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// File: hw/rv32i_core.sv
/* Single-cycle RV32I subset core. inst and mem_rdata must answer
   combinationally in the same cycle; there is no stall. */
module rv32i_core #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0,
  parameter int                      NUM_REGS = 32
) (
  input  logic                    clk,
  input  logic                    reset,
  output logic [rv_pkg::XLEN-1:0] pc,
  input  logic [rv_pkg::XLEN-1:0] inst,
  output logic                    mem_write,
  output logic [rv_pkg::XLEN-1:0] mem_addr,
  output logic [rv_pkg::XLEN-1:0] mem_wdata,
  input  logic [rv_pkg::XLEN-1:0] mem_rdata
);

  rv_pkg::inst_t           inst_fmt;        // Same word, format views
  rv_pkg::alu_op_t         alu_op;
  logic                    reg_write, alu_src, mem_to_reg;
  logic                    branch, jal, jalr, lui;
  logic [rv_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [rv_pkg::XLEN-1:0] rs1_data, rs2_data, rd_data;
  logic [rv_pkg::XLEN-1:0] alu_a, alu_b, alu_result, pc_plus4;
  logic                    flag_n, flag_z, flag_c, flag_v;

  assign inst_fmt = inst;

  rv_main_decoder i_main_decoder (
    .opcode(inst_fmt.r.opcode), .reg_write(reg_write), .alu_src(alu_src),
    .mem_to_reg(mem_to_reg), .mem_write(mem_write), .branch(branch),
    .jal(jal), .jalr(jalr), .lui(lui)
  );

  rv_alu_decoder i_alu_decoder (.inst(inst_fmt), .alu_op(alu_op));

  rv_imm_gen i_imm_gen (
    .inst(inst_fmt), .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b),
    .imm_u(imm_u), .imm_j(imm_j)
  );

  rv_regfile #(.NUM_REGS(NUM_REGS)) i_regfile (
    .clk(clk), .reset(reset), .we(reg_write),
    .rs1_addr(inst_fmt.r.rs1), .rs2_addr(inst_fmt.r.rs2), .rd_addr(inst_fmt.r.rd),
    .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_a = lui ? '0 : rs1_data;       // lui is 0 + imm_u

  always_comb begin
    if (lui)                        alu_b = imm_u;
    else if (alu_src && mem_write)  alu_b = imm_s;    // Store address
    else if (alu_src)               alu_b = imm_i;
    else                            alu_b = rs2_data;
  end

  rv_alu i_alu (
    .a(alu_a), .b(alu_b), .alu_op(alu_op), .result(alu_result),
    .flag_n(flag_n), .flag_z(flag_z), .flag_c(flag_c), .flag_v(flag_v)
  );

  rv_pc_unit #(.RESET_PC(RESET_PC)) i_pc_unit (
    .clk(clk), .reset(reset), .branch(branch), .jal(jal), .jalr(jalr),
    .funct3(inst_fmt.r.funct3), .flag_n(flag_n), .flag_z(flag_z),
    .flag_c(flag_c), .flag_v(flag_v), .imm_b(imm_b), .imm_j(imm_j),
    .alu_result(alu_result), .pc(pc), .pc_plus4(pc_plus4)
  );

  // Writeback, link value for both jumps
  always_comb begin
    if (jal || jalr)      rd_data = pc_plus4;
    else if (mem_to_reg)  rd_data = mem_rdata;
    else                  rd_data = alu_result;
  end

  assign mem_addr  = alu_result;
  assign mem_wdata = rs2_data;

endmodule

// File: dv/rv_asm.svh
/* Instruction encoders and reference results for the core testbench. Only
   the instructions the core keeps are encoded; sw is the only store. */
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

localparam logic [6:0] OPC_R      = 7'b0110011;
localparam logic [6:0] OPC_I      = 7'b0010011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;

function automatic logic [31:0] r_type(input int funct7, input int rs2, input int rs1,
                                       input int funct3, input int rd);
  return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], OPC_R};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [31:0] imm,
                                       input int rs1, input int funct3, input int rd);
  return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opc};  // Also lw and jalr
endfunction

function automatic logic [31:0] s_type(input logic [31:0] imm, input int rs2, input int rs1);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};  // sw
endfunction

function automatic logic [31:0] b_type(input logic [31:0] imm, input int rs2, input int rs1,
                                       input int funct3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
          OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [31:0] imm, input int rd);
  return {imm[31:12], rd[4:0], OPC_LUI};                     // lui
endfunction

function automatic logic [31:0] j_type(input logic [31:0] imm, input int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
endfunction

function automatic logic [31:0] sext12(input logic [31:0] value);
  return {{20{value[11]}}, value[11:0]};
endfunction

// Expected result of an R or I arithmetic op by funct3
function automatic logic [31:0] ref_alu(input int funct3, input int sub,
                                        input logic [31:0] a, input logic [31:0] b);
  case (funct3)
    7:       return a & b;
    6:       return a | b;
    4:       return a ^ b;
    default: return (sub != 0) ? a - b : a + b;              // Unknown codes add
  endcase
endfunction

function automatic logic branch_taken(input int funct3, input logic [31:0] a,
                                      input logic [31:0] b);
  case (funct3)
    0:       return a == b;                                   // beq
    4:       return $signed(a) < $signed(b);                  // blt
    7:       return a >= b;                                   // bgeu
    default: return 1'b0;
  endcase
endfunction

`endif

// File: dv/rv32i_core_tb.sv
/* Runs each table row as a small program on the core. Both memories hold
   256 words and answer combinationally; every program ends with a marker store. */
module rv32i_core_tb;

  localparam logic [31:0] RESET_PC   = 32'h0000_0040;
  localparam int          NUM_TESTS  = 8;
  localparam int          MAX_CYCLES = 200;
  localparam int          MAX_STORES = 12;
  localparam logic [31:0] DATA_BASE  = 32'h0000_0200;  // Result stores
  localparam logic [31:0] MEM_BASE   = 32'h0000_0180;  // Round trip base register
  localparam logic [31:0] MARKER     = 32'h0000_03FC;  // Last store of a program
  localparam int ARITH = 0, MEM_TRIP = 1, BRANCH = 2, JUMP = 3;
  localparam int R_F3  [5] = '{0, 0, 7, 6, 4};         // add sub and or xor
  localparam int R_SUB [5] = '{0, 1, 0, 0, 0};
  localparam int I_F3  [4] = '{0, 7, 6, 4};            // addi andi ori xori
  localparam int BR_F3 [3] = '{0, 4, 7};               // beq blt bgeu

  `include "rv_asm.svh"

  logic        clk;
  logic        reset;
  logic [31:0] pc, inst, mem_addr, mem_wdata, mem_rdata;
  logic        mem_write;
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] got_addr [$];                           // All stores of the run
  logic [31:0] got_data [$];
  logic [31:0] asm_pc;                                 // Address of next emitted word
  string       test_name [NUM_TESTS];
  int          test_kind [NUM_TESTS];
  logic [31:0] op_a [NUM_TESTS];
  logic [31:0] op_b [NUM_TESTS];
  logic [31:0] exp_addr [NUM_TESTS][MAX_STORES];
  logic [31:0] exp_data [NUM_TESTS][MAX_STORES];
  int          exp_count [NUM_TESTS];
  int          rows, passed, failed;

  rv32i_core #(.RESET_PC(RESET_PC), .NUM_REGS(32)) i_rv32i_core (
    .clk(clk), .reset(reset), .pc(pc), .inst(inst), .mem_write(mem_write),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  assign inst      = reset ? '0 : imem[pc[9:2]];       // Zero while in reset
  assign mem_rdata = dmem[mem_addr[9:2]];

  always @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < 256; k++) begin
        dmem[k] <= 32'hD00D_0000 ^ (k << 2);           // Refill on every reset
      end
    end else if (mem_write) begin
      dmem[mem_addr[9:2]] <= mem_wdata;
      got_addr.push_back(mem_addr);
      got_data.push_back(mem_wdata);
    end
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * MAX_CYCLES * 4);
    $display("Timeout: run did not finish within %0d time units", NUM_TESTS * MAX_CYCLES * 4);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] mem_offset(input logic [31:0] b);
    return {{24{b[5]}}, b[5:0], 2'b00};                // Word offset -128..124
  endfunction

  task automatic expect_store(input int row, input logic [31:0] addr, input logic [31:0] data);
    exp_addr[row][exp_count[row]] = addr;
    exp_data[row][exp_count[row]] = data;
    exp_count[row]++;
  endtask

  task automatic add_row(input string name, input int kind, input logic [31:0] a,
                         input logic [31:0] b);
    logic [31:0] off;
    off = mem_offset(b);
    test_name[rows] = name;
    test_kind[rows] = kind;
    op_a[rows] = a;
    op_b[rows] = b;
    exp_count[rows] = 0;
    case (kind)
      ARITH: begin
        expect_store(rows, DATA_BASE, a);              // lui plus addi load
        for (int k = 0; k < 5; k++) begin
          expect_store(rows, DATA_BASE + 4 * (k + 1), ref_alu(R_F3[k], R_SUB[k], a, b));
        end
        for (int k = 0; k < 4; k++) begin
          expect_store(rows, DATA_BASE + 4 * (k + 6), ref_alu(I_F3[k], 0, a, sext12(b)));
        end
        expect_store(rows, DATA_BASE + 40, 32'h0);     // x0 stays zero
      end
      MEM_TRIP: begin
        expect_store(rows, MEM_BASE + off, a);
        expect_store(rows, MEM_BASE - off - 4, a + 1);
      end
      BRANCH: begin
        for (int k = 0; k < 3; k++) begin
          expect_store(rows, DATA_BASE + 4 * k,
                       branch_taken(BR_F3[k], a, b) ? 32'h200 + k : 32'h100 + k);
        end
      end
      default: begin
        // Jump program at RESET_PC with jal at +0 and jalr at +28
        expect_store(rows, DATA_BASE + 16, RESET_PC + 4);
        expect_store(rows, DATA_BASE + 20, 32'h111);
        expect_store(rows, DATA_BASE + 24, RESET_PC + 32);
        expect_store(rows, DATA_BASE + 28, 32'h222);
      end
    endcase
    rows++;
  endtask

  task automatic emit(input logic [31:0] word);
    imem[asm_pc[9:2]] = word;
    asm_pc = asm_pc + 4;
  endtask

  task automatic load_const(input int rd, input logic [31:0] value);
    emit(u_type(value + 32'h800, rd));                 // Rounded for signed addi
    emit(i_type(OPC_I, value, rd, 0, rd));
  endtask

  task automatic build_program(input int t);
    logic [31:0] a, b, off, jimm;
    a = op_a[t];
    b = op_b[t];
    off = mem_offset(b);
    jimm = {26'b0, a[5:0]};
    for (int k = 0; k < 256; k++) begin
      imem[k] = {k[7:0], 17'h0, 7'h7F};                // Unknown opcode without effect
    end
    asm_pc = RESET_PC;
    case (test_kind[t])
      ARITH: begin
        load_const(5, a);
        load_const(6, b);
        emit(s_type(DATA_BASE, 5, 0));
        for (int k = 0; k < 5; k++) begin
          emit(r_type(R_SUB[k] * 32, 6, 5, R_F3[k], 7));
          emit(s_type(DATA_BASE + 4 * (k + 1), 7, 0));
        end
        for (int k = 0; k < 4; k++) begin
          emit(i_type(OPC_I, b, 5, I_F3[k], 7));
          emit(s_type(DATA_BASE + 4 * (k + 6), 7, 0));
        end
        emit(r_type(0, 6, 5, 0, 0));                   // Write to x0
        emit(s_type(DATA_BASE + 40, 0, 0));
      end
      MEM_TRIP: begin
        load_const(5, a);
        emit(i_type(OPC_I, MEM_BASE, 0, 0, 8));
        emit(s_type(off, 5, 8));
        emit(i_type(OPC_LOAD, off, 8, 2, 9));
        emit(i_type(OPC_I, 1, 9, 0, 9));
        emit(s_type(32'h0 - off - 4, 9, 8));
      end
      BRANCH: begin
        load_const(5, a);
        load_const(6, b);
        for (int k = 0; k < 3; k++) begin
          emit(b_type(12, 6, 5, BR_F3[k]));            // Taken path at +12
          emit(i_type(OPC_I, 32'h100 + k, 0, 0, 7));
          emit(j_type(8, 0));
          emit(i_type(OPC_I, 32'h200 + k, 0, 0, 7));
          emit(s_type(DATA_BASE + 4 * k, 7, 0));
        end
      end
      default: begin
        emit(j_type(12, 10));
        emit(i_type(OPC_I, 32'h7AD, 0, 0, 12));        // Skipped
        emit(s_type(DATA_BASE + 16, 12, 0));
        emit(s_type(DATA_BASE + 16, 10, 0));
        emit(i_type(OPC_I, 32'h111, 0, 0, 12));
        emit(s_type(DATA_BASE + 20, 12, 0));
        emit(i_type(OPC_I, RESET_PC + 41 - jimm, 0, 0, 13));  // Odd target sum
        emit(i_type(OPC_JALR, jimm, 13, 0, 14));
        emit(i_type(OPC_I, 32'h7AE, 0, 0, 12));        // Skipped
        emit(s_type(DATA_BASE + 24, 12, 0));
        emit(s_type(DATA_BASE + 24, 14, 0));           // jalr lands here at RESET_PC + 40
        emit(i_type(OPC_I, 32'h222, 0, 0, 12));
        emit(s_type(DATA_BASE + 28, 12, 0));
      end
    endcase
    emit(s_type(MARKER, 0, 0));
    emit(j_type(0, 0));                                // Park
  endtask

  task automatic run_test(input int t);
    int  first, errs, n;
    bit  done;
    errs = 0;
    done = 1'b0;
    @(posedge clk);
    reset <= 1'b1;
    repeat (9) @(posedge clk);
    build_program(t);
    @(negedge clk);
    if (pc !== RESET_PC || mem_write !== 1'b0) begin
      $display("mismatch at time %0t: %s in reset pc %h mem_write %b, expected pc %h",
               $time, test_name[t], pc, mem_write, RESET_PC);
      errs++;
    end
    first = got_addr.size();
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (pc !== RESET_PC) begin
      $display("mismatch at time %0t: %s first fetch from pc %h, expected pc %h",
               $time, test_name[t], pc, RESET_PC);
      errs++;
    end
    for (n = 0; n < MAX_CYCLES - 20 && !done; n++) begin
      @(negedge clk);
      if (pc[1:0] !== 2'b00) begin
        $display("mismatch at time %0t: %s pc %h is not word aligned",
                 $time, test_name[t], pc);
        errs++;
      end
      done = got_addr.size() > first && got_addr[got_addr.size() - 1] == MARKER;
    end
    if (!done) begin
      $display("%s: program never reached its final store to the marker address", test_name[t]);
      errs++;
    end else begin
      n = got_addr.size() - first - 1;                 // Stores before the marker
      if (n != exp_count[t]) begin
        $display("mismatch at time %0t: %s made %0d stores, expected %0d",
                 $time, test_name[t], n, exp_count[t]);
        errs++;
      end
      for (int i = 0; i < n && i < exp_count[t]; i++) begin
        if (got_addr[first + i] !== exp_addr[t][i] || got_data[first + i] !== exp_data[t][i]) begin
          $display("mismatch at time %0t: %s store %0d at %h data %h, expected %h data %h",
                   $time, test_name[t], i, got_addr[first + i], got_data[first + i],
                   exp_addr[t][i], exp_data[t][i]);
          errs++;
        end
      end
    end
    if (errs == 0) begin
      passed++;
      $display("%s: PASS", test_name[t]);
    end else begin
      failed++;
      $display("%s: FAIL with %0d errors", test_name[t], errs);
    end
  endtask

  initial begin
    logic [31:0] a, b;
    reset = 1'b1;
    rows = 0;
    passed = 0;
    failed = 0;
    asm_pc = RESET_PC;
    void'($urandom(77));
    a = $urandom();
    b = $urandom();
    add_row("arith_rand_a", ARITH, a, b);
    a = $urandom();
    b = $urandom();
    add_row("arith_rand_b", ARITH, a, b);
    a = $urandom();
    b = $urandom();
    add_row("mem_trip_a", MEM_TRIP, a, b);
    a = $urandom();
    b = $urandom();
    add_row("mem_trip_b", MEM_TRIP, a, b);
    a = $urandom();
    b = $urandom();
    add_row("branch_rand", BRANCH, a, b);
    add_row("branch_equal", BRANCH, b, b);
    add_row("branch_sign", BRANCH, a, a ^ 32'h8000_0000);  // Signed and unsigned order differ
    a = $urandom();
    add_row("jump_link", JUMP, a, 32'h0);
    for (int t = 0; t < rows; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+dv
hw/rv_pkg.sv
hw/rv_main_decoder.sv
hw/rv_alu_decoder.sv
hw/rv_imm_gen.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_pc_unit.sv
hw/rv32i_core.sv
dv/rv32i_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and judges the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/rv32i_core_tb_sim

verilator --binary --timing -f sources.f --top-module rv32i_core_tb -o rv32i_core_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
  echo "No verdict found in $LOG"
  exit 1
fi
exit 0
